/* Bender.yml */
package:
  name: test_controller

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/host_bus_pkg.sv
      - hdl/switch_pkg.sv
      - hdl/reg_decoder.sv
      - hdl/switch_matrix.sv
      - hdl/activity_stretch.sv
      - hdl/sensor_mode.sv
      - hdl/test_controller.sv
  - target: test
    files:
      - dv/test_controller_tb.sv

/* dv/test_controller_tb.sv */
`include "switch_config.svh"

module test_controller_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import host_bus_pkg::*;
	import switch_pkg::*;

	typedef struct packed {
		logic wr;
		logic [`REG_CODE_W-1:0] code;
		logic [`DATA_W-1:0] data;
		logic [7:0] wait_cyc; // cycles watched after the access
		logic stretch; // matrix empties in this row
		line_set_t sel;
		line_set_t sus;
		logic [`CTRL_LINES-1:0] ctrl;
		sense_ctrl_t sense;
		logic [`DATA_W-1:0] rdata;
	} row_t;

	logic clk = 1'b0;
	logic rst_;
	host_req_t host_req;
	host_rsp_t host_rsp;
	line_set_t sel;
	line_set_t sus;
	logic [`CTRL_LINES-1:0] ctrl_en;
	logic active;
	sense_ctrl_t sense;

	row_t rows[$];
	row_t prev = '0; // expected state before the current row
	line_set_t m_sel = '0; // reference model state
	line_set_t m_sus = '0;
	logic [`CTRL_LINES-1:0] m_ctrl = '0;
	switch_cmd_t m_sel_cmd = '0;
	switch_cmd_t m_sus_cmd = '0;
	logic [`DATA_W-1:0] m_sens = '0;
	logic [7:0] m_err = '0;
	int error_count = 0;
	int check_count = 0;
	int watchdog_cycles = 0;
	logic table_ready = 1'b0;

	test_controller DUT (.*);

	always #50 clk = ~clk;

	// field positions of a command word on the bus
	function automatic logic [`DATA_W-1:0] cmd_word(input logic work_en, input logic [2:0] group,
		input logic [4:0] index, input logic enable, input logic [3:0] mode);
		return {15'b0, index, work_en, group, 3'b0, enable, mode};
	endfunction

	function automatic line_set_t lines_hit(input switch_cmd_t c);
		line_set_t m;
		logic [`GROUP_LINES-1:0] pick; // whole group or a single line
		m = '0;
		pick = (c.mode == `MODE_GROUP) ? {`GROUP_LINES{1'b1}} : `GROUP_LINES'(1) << c.index;
		if (c.mode == `MODE_FULL)
			m = '1;
		else if (c.mode == `MODE_SECTION)
			m = {pick, pick, pick, {(`D_LINES-`D_LOW_LINES){1'b0}}, pick};
		else if (c.mode == `MODE_GROUP || c.mode == `MODE_ADDR)
			case (c.group)
				`GRP_A: m.a = pick;
				`GRP_B: m.b = pick;
				`GRP_C: m.c = pick;
				`GRP_D_LOW: m.d[`D_LOW_LINES-1:0] = pick;
				`GRP_D_HIGH: m.d[`D_LINES-1:`D_LOW_LINES] = pick[`D_LINES-`D_LOW_LINES-1:0];
				default: ;
			endcase
		return m;
	endfunction

	function automatic logic [`CTRL_LINES-1:0] ctrl_hit(input switch_cmd_t c);
		logic [`CTRL_LINES-1:0] m;
		m = '0;
		if (c.mode == `MODE_FULL || (c.mode == `MODE_GROUP && c.group == `GRP_CTRL))
			m = '1;
		else if (c.mode == `MODE_ADDR && c.group == `GRP_CTRL)
			m[c.index % `CTRL_LINES] = 1'b1;
		return m;
	endfunction

	function automatic sense_ctrl_t decode_sense(input logic [`DATA_W-1:0] w);
		sense_ctrl_t s;
		s = '0;
		for (int n = 0; n < 4; n++)
		begin
			s.v[n] = w[2*n +: 2] == 2'b01;
			s.r[n] = w[2*n +: 2] == 2'b10;
			s.gnd[n] = w[2*n +: 2] == 2'b11;
		end
		s.check_a = w[11:8];
		s.check_b = w[15:12];
		s.check_c = w[19:16];
		return s;
	endfunction

	// runs one access through the model and queues it with its expected results
	task automatic add_row(input logic wr, input logic [`REG_CODE_W-1:0] code,
		input logic [`DATA_W-1:0] data, input int wait_cyc);
		row_t r;
		switch_cmd_t cmd;
		line_set_t m;
		logic [`CTRL_LINES-1:0] cm;
		logic busy;
		logic is_cmd;
		busy = |m_sel || |m_sus;
		cmd = data[19:0];
		m = lines_hit(cmd);
		cm = ctrl_hit(cmd);
		is_cmd = wr && (code == `CODE_CMD_SEL || code == `CODE_CMD_SUS);
		r = '0;
		r.wr = wr;
		r.code = code;
		r.data = data;
		if (!wr)
			case (code)
				`CODE_CMD_SEL: r.rdata = {{(`DATA_W-18){1'b0}}, busy, m_sel_cmd[16:0]};
				`CODE_CMD_SUS: r.rdata = {{(`DATA_W-20){1'b0}}, m_sus_cmd};
				`CODE_SENS: r.rdata = m_sens;
				`CODE_ERR: r.rdata = {{(`DATA_W-8){1'b0}}, m_err};
				default: ;
			endcase
		if (!wr && code == `CODE_ERR)
			m_err = '0;
		if (code != `CODE_CMD_SEL && code != `CODE_CMD_SUS && code != `CODE_SENS
			&& code != `CODE_ERR)
			m_err[0] = 1'b1;
		if (is_cmd && (cmd.mode == 4'b0 || (cmd.mode & (cmd.mode - 4'd1)) != 4'b0))
			m_err[7] = 1'b1; // not one-hot
		if (wr && code == `CODE_CMD_SEL)
			m_sel_cmd = cmd;
		if (wr && code == `CODE_CMD_SUS)
			m_sus_cmd = cmd;
		if (is_cmd && !m_sel_cmd.work_en && !m_sus_cmd.work_en)
		begin
			m_sel = '0;
			m_sus = '0;
			m_ctrl = '0;
		end
		else if (is_cmd && code == `CODE_CMD_SEL)
		begin
			m_sel = cmd.enable ? m_sel | m : m_sel & ~m;
			m_sus = cmd.enable ? m_sus & ~m : m_sus;
			m_ctrl = cmd.enable ? m_ctrl | cm : m_ctrl & ~cm;
		end
		else if (is_cmd)
		begin
			m_sus = cmd.enable ? m_sus | m : m_sus & ~m;
			m_sel = cmd.enable ? m_sel & ~m : m_sel;
		end
		if (wr && code == `CODE_SENS)
			m_sens = data;
		r.sel = m_sel;
		r.sus = m_sus;
		r.ctrl = m_ctrl;
		r.sense = decode_sense(m_sens);
		r.stretch = busy && !(|m_sel || |m_sus);
		r.wait_cyc = (r.stretch && wait_cyc < `STRETCH_CYCLES + 2) ? `STRETCH_CYCLES + 2 : wait_cyc;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [4:0] idx_a;
		logic [4:0] idx_d;
		logic [4:0] idx_s;
		logic [4:0] idx_b;
		int max_wait;
		idx_a = 5'($urandom);
		idx_d = 5'($urandom); // past 24 is a no-op in d-high
		idx_s = 5'($urandom);
		idx_b = 5'($urandom);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, 3'd0, 5'd0, 1'b1, `MODE_FULL), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, `GRP_A, 5'd0, 1'b0, `MODE_GROUP), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, `GRP_CTRL, 5'd0, 1'b0, `MODE_GROUP), 3);
		add_row(1'b1, `CODE_CMD_SUS, cmd_word(1'b1, `GRP_B, 5'd0, 1'b1, `MODE_GROUP), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, `GRP_A, idx_a, 1'b1, `MODE_ADDR), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, `GRP_D_HIGH, idx_d, 1'b0, `MODE_ADDR), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, `GRP_CTRL, 5'd2, 1'b1, `MODE_ADDR), 3);
		add_row(1'b1, `CODE_CMD_SUS, cmd_word(1'b1, 3'd0, idx_s, 1'b1, `MODE_SECTION), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, 3'd0, idx_s, 1'b1, `MODE_SECTION), 3);
		add_row(1'b0, `CODE_CMD_SEL, '0, 3);
		add_row(1'b0, `CODE_CMD_SUS, '0, 3);
		add_row(1'b1, `CODE_CMD_SUS, cmd_word(1'b1, `GRP_B, idx_b, 1'b0, `MODE_ADDR), 3);
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b0, `GRP_C, 5'd0, 1'b0, `MODE_FULL), 3);
		add_row(1'b1, `CODE_CMD_SUS, cmd_word(1'b0, `GRP_A, 5'd0, 1'b0, `MODE_GROUP), 3);
		add_row(1'b0, `CODE_CMD_SEL, '0, 3);
		add_row(1'b1, `CODE_SENS, 32'h5a3c_96e4, 3);
		add_row(1'b0, `CODE_SENS, '0, 3);
		add_row(1'b1, `CODE_SENS, $urandom, 3);
		add_row(1'b0, 16'h1234, '0, 3); // unknown code
		add_row(1'b1, `CODE_CMD_SEL, cmd_word(1'b1, `GRP_A, 5'd0, 1'b1, 4'b0011), 3);
		add_row(1'b0, `CODE_ERR, '0, 0); // second read follows back to back
		add_row(1'b0, `CODE_ERR, '0, 3);
		max_wait = 0;
		foreach (rows[i])
			if (rows[i].wait_cyc > max_wait)
				max_wait = rows[i].wait_cyc;
		watchdog_cycles = rows.size() * (max_wait + 2) + `STRETCH_CYCLES + 20;
	endtask

	task automatic compare(input string what, input logic [151:0] got,
		input logic [151:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			error_count++;
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// c counts edges after the one that took the access
	task automatic check_outputs(input row_t r, input int c);
		row_t e;
		logic busy;
		e = (c == 0) ? prev : r;
		busy = |e.sel || |e.sus;
		compare("sel", sel, e.sel);
		compare("sus", sus, e.sus);
		compare("ctrl_en", ctrl_en, e.ctrl);
		if (c == 1 && r.wr && r.code == `CODE_SENS)
			compare("sense", sense, '0); // live word cleared first
		else
			compare("sense", sense, e.sense);
		compare("active", active, (r.stretch && c > 0) ? c <= `STRETCH_CYCLES : busy);
		compare("rvalid", host_rsp.rvalid, c == 0 && !r.wr);
		compare("rdata", host_rsp.rdata, (c == 0 && !r.wr) ? r.rdata : '0);
	endtask

	initial
	begin
		rst_ = 1'b0;
		host_req = '0;
		void'($urandom(32'hfdd6d5b8));
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge clk);
		#5;
		rst_ = 1'b1;
		prev.wr = 1'b1; // no read pending out of reset
		check_outputs(prev, 0);
		for (int i = 0; i < rows.size(); i++)
		begin
			host_req.valid = 1'b1;
			host_req.wr = rows[i].wr;
			host_req.code = rows[i].code;
			host_req.wdata = rows[i].data;
			@(posedge clk);
			#5;
			host_req = '0;
			check_outputs(rows[i], 0);
			for (int c = 1; c <= rows[i].wait_cyc; c++)
			begin
				@(posedge clk);
				#5;
				check_outputs(rows[i], c);
			end
			prev = rows[i];
		end
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		wait (table_ready);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the stimulus table did not finish within %0d clock cycles",
			watchdog_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* hdl/activity_stretch.sv */
`include "switch_config.svh"

module activity_stretch (
	input  logic                  clk,
	input  logic                  rst_,
	input  switch_pkg::line_set_t sel,
	input  switch_pkg::line_set_t sus,
	output logic                  active
);
	localparam int CNT_W = $clog2(`STRETCH_CYCLES + 1);

	logic any_set;
	logic [CNT_W-1:0] hold_cnt;

	assign any_set = |sel || |sus;

	always_ff @(posedge clk)
	begin
		if (!rst_)
			hold_cnt <= '0;
		else if (any_set)
			hold_cnt <= CNT_W'(`STRETCH_CYCLES); // reload while switched
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	// high through the switching and the hold time after it
	assign active = any_set || (hold_cnt != '0);

endmodule

/* hdl/host_bus_pkg.sv */
`include "switch_config.svh"

package host_bus_pkg;

	// one host access, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic wr; // low for a read
		logic [`REG_CODE_W-1:0] code;
		logic [`DATA_W-1:0] wdata;
	} host_req_t;

	// read response, one cycle after the read access
	typedef struct packed {
		logic rvalid;
		logic [`DATA_W-1:0] rdata; // zero when rvalid is low
	} host_rsp_t;

endpackage

/* hdl/reg_decoder.sv */
`include "switch_config.svh"

module reg_decoder (
	input  logic                      clk,
	input  logic                      rst_,
	input  host_bus_pkg::host_req_t   host_req,
	output host_bus_pkg::host_rsp_t   host_rsp,
	output logic                      sel_wr,
	output logic                      sus_wr,
	output logic                      sens_wr,
	output switch_pkg::switch_cmd_t   cmd_data,
	output logic [`DATA_W-1:0]        sens_data,
	input  switch_pkg::switch_cmd_t   sel_cmd,
	input  switch_pkg::switch_cmd_t   sus_cmd,
	input  logic [`DATA_W-1:0]        sens_word,
	input  logic                      active
);
	import switch_pkg::*;

	localparam int CMD_W = $bits(switch_cmd_t);

	logic rd_acc;
	logic wr_acc;
	logic hit_sel;
	logic hit_sus;
	logic hit_sens;
	logic hit_err;
	logic known;
	logic mode_bad;
	logic err_rd; // error register read in this cycle
	logic [7:0] err;
	logic [`DATA_W-1:0] rd_mux;

	assign rd_acc = host_req.valid && !host_req.wr;
	assign wr_acc = host_req.valid && host_req.wr;

	assign hit_sel = host_req.code == `CODE_CMD_SEL;
	assign hit_sus = host_req.code == `CODE_CMD_SUS;
	assign hit_sens = host_req.code == `CODE_SENS;
	assign hit_err = host_req.code == `CODE_ERR;
	assign known = hit_sel || hit_sus || hit_sens || hit_err;

	assign sel_wr = wr_acc && hit_sel;
	assign sus_wr = wr_acc && hit_sus;
	assign sens_wr = wr_acc && hit_sens;
	assign cmd_data = host_req.wdata[CMD_W-1:0];
	assign sens_data = host_req.wdata;
	assign err_rd = rd_acc && hit_err;

	// only the four one-hot codes are legal modes
	assign mode_bad = host_req.wdata[3:0] != `MODE_FULL
		&& host_req.wdata[3:0] != `MODE_GROUP
		&& host_req.wdata[3:0] != `MODE_ADDR
		&& host_req.wdata[3:0] != `MODE_SECTION;

	always_ff @(posedge clk)
	begin
		if (!rst_)
			err <= '0;
		else
		begin
			err[0] <= (err[0] && !err_rd) || (host_req.valid && !known); // unknown code
			err[6:1] <= '0;
			err[7] <= (err[7] && !err_rd) || (sel_wr && mode_bad) || (sus_wr && mode_bad);
		end
	end

	always_comb
	begin
		rd_mux = '0;
		if (rd_acc && hit_sel)
			rd_mux = {{(`DATA_W-18){1'b0}}, active, sel_cmd.index, sel_cmd.work_en,
				sel_cmd.group, sel_cmd.spare_lo, sel_cmd.enable, sel_cmd.mode};
		else if (rd_acc && hit_sus)
			rd_mux = {{(`DATA_W-CMD_W){1'b0}}, sus_cmd};
		else if (rd_acc && hit_sens)
			rd_mux = sens_word;
		else if (rd_acc && hit_err)
			rd_mux = {{(`DATA_W-8){1'b0}}, err}; // value before the clear
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
			host_rsp <= '0;
		else
		begin
			host_rsp.rvalid <= rd_acc;
			host_rsp.rdata <= rd_mux;
		end
	end

endmodule

/* hdl/sensor_mode.sv */
`include "switch_config.svh"

module sensor_mode (
	input  logic                    clk,
	input  logic                    rst_,
	input  logic                    sens_wr,
	input  logic [`DATA_W-1:0]      sens_data,
	output logic [`DATA_W-1:0]      sens_word,
	output switch_pkg::sense_ctrl_t sense
);
	import switch_pkg::*;

	localparam int CHANNELS = $bits(sense.v);

	logic [`DATA_W-1:0] hold; // captured write data
	logic load_pend;
	sense_ctrl_t sense_next;

	// live word goes to zero first, then takes the new value
	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			hold <= '0;
			sens_word <= '0;
			load_pend <= 1'b0;
		end
		else if (sens_wr)
		begin
			hold <= sens_data;
			sens_word <= '0;
			load_pend <= 1'b1;
		end
		else if (load_pend)
		begin
			sens_word <= hold;
			load_pend <= 1'b0;
		end
	end

	always_comb
	begin
		for (int n = 0; n < CHANNELS; n++)
		begin
			sense_next.v[n] = sens_word[2*n +: 2] == 2'b01;
			sense_next.r[n] = sens_word[2*n +: 2] == 2'b10;
			sense_next.gnd[n] = sens_word[2*n +: 2] == 2'b11;
		end
		sense_next.check_a = sens_word[11:8];
		sense_next.check_b = sens_word[15:12];
		sense_next.check_c = sens_word[19:16];
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
			sense <= '0;
		else
			sense <= sense_next; // one cycle behind the live word
	end

endmodule

/* hdl/switch_config.svh */
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// relay matrix geometry
`define GROUP_LINES 32 // lines in groups a, b and c
`define D_LINES 56
`define D_LOW_LINES 32 // section mode reaches only this part of d
`define CTRL_LINES 4

// host bus
`define DATA_W 32
`define REG_CODE_W 16

`define CODE_CMD_SEL 16'h1300 // select command, lines to sensors
`define CODE_CMD_SUS 16'h1310 // substitute command, lines to dac
`define CODE_SENS 16'h1320
`define CODE_ERR 16'hF000 // clears on read

`define MODE_FULL 4'b0001
`define MODE_GROUP 4'b0010
`define MODE_ADDR 4'b0100
`define MODE_SECTION 4'b1000

`define GRP_A 3'd1
`define GRP_B 3'd2
`define GRP_C 3'd3
`define GRP_D_LOW 3'd4 // d lines 1 to 32
`define GRP_D_HIGH 3'd5 // d lines 33 to 56
`define GRP_CTRL 3'd6 // select side only

`define STRETCH_CYCLES 25 // activity hold after the matrix empties

`endif

/* hdl/switch_matrix.sv */
`include "switch_config.svh"

module switch_matrix (
	input  logic                      clk,
	input  logic                      rst_,
	input  logic                      sel_wr,
	input  logic                      sus_wr,
	input  switch_pkg::switch_cmd_t   cmd_data,
	output switch_pkg::switch_cmd_t   sel_cmd,
	output switch_pkg::switch_cmd_t   sus_cmd,
	output switch_pkg::line_set_t     sel,
	output switch_pkg::line_set_t     sus,
	output logic [`CTRL_LINES-1:0]    ctrl_en
);
	import switch_pkg::*;

	localparam int HIGH_LINES = `D_LINES - `D_LOW_LINES;

	logic apply_sel; // command word written last cycle
	logic apply_sus;
	line_set_t sel_mask;
	line_set_t sus_mask;
	line_set_t sel_next;
	line_set_t sus_next;
	logic [`CTRL_LINES-1:0] ctrl_mask;
	logic [`CTRL_LINES-1:0] ctrl_next;

	// relay lines addressed by one command
	function automatic line_set_t lines_of(input switch_cmd_t cmd);
		line_set_t m;
		logic [`GROUP_LINES-1:0] one;
		m = '0;
		one = '0;
		one[cmd.index] = 1'b1;
		case (cmd.mode)
			`MODE_FULL: m = '1;
			`MODE_GROUP:
				case (cmd.group)
					`GRP_A: m.a = '1;
					`GRP_B: m.b = '1;
					`GRP_C: m.c = '1;
					`GRP_D_LOW: m.d[`D_LOW_LINES-1:0] = '1;
					`GRP_D_HIGH: m.d[`D_LINES-1:`D_LOW_LINES] = '1;
					default: ; // ctrl or unused code
				endcase
			`MODE_ADDR:
				case (cmd.group)
					`GRP_A: m.a = one;
					`GRP_B: m.b = one;
					`GRP_C: m.c = one;
					`GRP_D_LOW: m.d[`D_LOW_LINES-1:0] = one;
					`GRP_D_HIGH:
						if (cmd.index < HIGH_LINES) // d-high has only 24 lines
							m.d[`D_LINES-1:`D_LOW_LINES] = one[HIGH_LINES-1:0];
					default: ;
				endcase
			`MODE_SECTION:
			begin
				m.a = one;
				m.b = one;
				m.c = one;
				m.d[`D_LOW_LINES-1:0] = one;
			end
			default: ; // illegal mode, nothing moves
		endcase
		return m;
	endfunction

	// control-enable lines, select side only
	function automatic logic [`CTRL_LINES-1:0] ctrl_of(input switch_cmd_t cmd);
		logic [`CTRL_LINES-1:0] m;
		m = '0;
		if (cmd.mode == `MODE_FULL)
			m = '1;
		else if (cmd.mode == `MODE_GROUP && cmd.group == `GRP_CTRL)
			m = '1;
		else if (cmd.mode == `MODE_ADDR && cmd.group == `GRP_CTRL)
			m[cmd.index[1:0]] = 1'b1;
		return m;
	endfunction

	// a line is never on both sides at once
	function automatic void switch_lines(input logic en, input line_set_t mask,
		inout line_set_t own, inout line_set_t other);
		if (en)
		begin
			own = own | mask;
			other = other & ~mask;
		end
		else
			own = own & ~mask;
	endfunction

	always_comb
	begin
		sel_mask = lines_of(sel_cmd);
		sus_mask = lines_of(sus_cmd);
		ctrl_mask = ctrl_of(sel_cmd);
		sel_next = sel;
		sus_next = sus;
		ctrl_next = ctrl_en;
		if (apply_sel)
		begin
			switch_lines(sel_cmd.enable, sel_mask, sel_next, sus_next);
			ctrl_next = sel_cmd.enable ? (ctrl_next | ctrl_mask) : (ctrl_next & ~ctrl_mask);
		end
		if (apply_sus)
			switch_lines(sus_cmd.enable, sus_mask, sus_next, sel_next);
	end

	always_ff @(posedge clk)
	begin
		if (!rst_)
		begin
			sel_cmd <= '0;
			sus_cmd <= '0;
			apply_sel <= 1'b0;
			apply_sus <= 1'b0;
			sel <= '0;
			sus <= '0;
			ctrl_en <= '0;
		end
		else
		begin
			if (sel_wr)
				sel_cmd <= cmd_data;
			if (sus_wr)
				sus_cmd <= cmd_data;
			apply_sel <= sel_wr;
			apply_sus <= sus_wr;
			if (!sel_cmd.work_en && !sus_cmd.work_en) // no work enable, drop everything
			begin
				sel <= '0;
				sus <= '0;
				ctrl_en <= '0;
			end
			else
			begin
				sel <= sel_next;
				sus <= sus_next;
				ctrl_en <= ctrl_next;
			end
		end
	end

endmodule

/* hdl/switch_pkg.sv */
`include "switch_config.svh"

package switch_pkg;

	// command word as it sits in bits 19:0 of the data word
	typedef struct packed {
		logic [2:0] spare_hi; // bits 19:17, stored and read back
		logic [4:0] index; // line number minus one
		logic work_en; // bit 11
		logic [2:0] group;
		logic [2:0] spare_lo; // bits 7:5
		logic enable; // set or clear the addressed lines
		logic [3:0] mode; // one-hot
	} switch_cmd_t;

	// one full set of relay lines, bit 0 is line 1
	typedef struct packed {
		logic [`GROUP_LINES-1:0] a;
		logic [`GROUP_LINES-1:0] b;
		logic [`GROUP_LINES-1:0] c;
		logic [`D_LINES-1:0] d;
	} line_set_t;

	// sensor channel controls, bit n-1 belongs to channel n
	typedef struct packed {
		logic [3:0] v; // analog
		logic [3:0] r; // parametric
		logic [3:0] gnd; // discrete
		logic [3:0] check_a;
		logic [3:0] check_b;
		logic [3:0] check_c;
	} sense_ctrl_t;

endpackage

/* hdl/test_controller.sv */
`include "switch_config.svh"

module test_controller (
	input  logic                      clk,
	input  logic                      rst_,
	input  host_bus_pkg::host_req_t   host_req,
	output host_bus_pkg::host_rsp_t   host_rsp,
	output switch_pkg::line_set_t     sel,
	output switch_pkg::line_set_t     sus,
	output logic [`CTRL_LINES-1:0]    ctrl_en,
	output logic                      active,
	output switch_pkg::sense_ctrl_t   sense
);
	import switch_pkg::*;

	logic sel_wr;
	logic sus_wr;
	logic sens_wr;
	switch_cmd_t cmd_data;
	switch_cmd_t sel_cmd; // stored words, back for read-back
	switch_cmd_t sus_cmd;
	logic [`DATA_W-1:0] sens_data;
	logic [`DATA_W-1:0] sens_word;

	reg_decoder u_reg_decoder (
		.clk       (clk),
		.rst_      (rst_),
		.host_req  (host_req),
		.host_rsp  (host_rsp),
		.sel_wr    (sel_wr),
		.sus_wr    (sus_wr),
		.sens_wr   (sens_wr),
		.cmd_data  (cmd_data),
		.sens_data (sens_data),
		.sel_cmd   (sel_cmd),
		.sus_cmd   (sus_cmd),
		.sens_word (sens_word),
		.active    (active)
	);

	switch_matrix u_switch_matrix (
		.clk      (clk),
		.rst_     (rst_),
		.sel_wr   (sel_wr),
		.sus_wr   (sus_wr),
		.cmd_data (cmd_data),
		.sel_cmd  (sel_cmd),
		.sus_cmd  (sus_cmd),
		.sel      (sel),
		.sus      (sus),
		.ctrl_en  (ctrl_en)
	);

	activity_stretch u_activity_stretch (
		.clk    (clk),
		.rst_   (rst_),
		.sel    (sel),
		.sus    (sus),
		.active (active)
	);

	sensor_mode u_sensor_mode (
		.clk       (clk),
		.rst_      (rst_),
		.sens_wr   (sens_wr),
		.sens_data (sens_data),
		.sens_word (sens_word),
		.sense     (sense)
	);

endmodule

/* test_controller.f */
+incdir+hdl
hdl/host_bus_pkg.sv
hdl/switch_pkg.sv
hdl/reg_decoder.sv
hdl/switch_matrix.sv
hdl/activity_stretch.sv
hdl/sensor_mode.sv
hdl/test_controller.sv
dv/test_controller_tb.sv
